/* Makefile */
VERILATOR ?= verilator
TOP ?= l1_read_cache_tb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -qx 'sim passed' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
logic/cache_pkg.sv
logic/lookup_if.sv
logic/tag_store.sv
logic/way_data_ram.sv
logic/read_port.sv
logic/l1_read_cache.sv
tests/l1_read_cache_sva.sv
tests/l1_read_cache_tb.sv

/* logic/cache_pkg.sv */
// Shared geometry, address layout and small types for the 4-way L1 read cache
// Referenced everywhere by scoped names, never imported
package cache_pkg;

	localparam int WAYS = 4;
	localparam int SETS = 16;
	localparam int LINE_BYTES = 64;
	localparam int TAG_WIDTH = 22;
	localparam int INDEX_WIDTH = 4;
	localparam int OFFSET_WIDTH = 6;
	localparam int WORD_WIDTH = 64;
	localparam int LINE_WIDTH = LINE_BYTES * 8;
	localparam int AGE_TIMER_WIDTH = 16;

	// Entry age, 0 is empty and 3 is most recent
	typedef logic [1:0] status_t;

	localparam status_t STATUS_NEWEST = 2'd3;
	localparam status_t STATUS_INVALID = 2'd0;

	typedef logic [1:0] way_t;
	typedef logic [INDEX_WIDTH-1:0] index_t;
	typedef logic [WORD_WIDTH-1:0] word_t;
	typedef logic [LINE_WIDTH-1:0] line_t;

	// Request address, seen either as a plain word or split for lookup
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [TAG_WIDTH-1:0] tag;
			index_t index;
			logic [OFFSET_WIDTH-1:0] offset;	// Top 3 bits pick the word
		} fields;
	} addr_u;

endpackage

/* logic/l1_read_cache.sv */
// Top of the 4-way set-associative L1 read cache, 16 sets of 64-byte lines
// Reads return a hit flag and a 64-bit word one cycle later; fills write whole lines
`timescale 1ns/1ps

module l1_read_cache (
	input logic iCLOCK,
	input logic inRESET,
	input logic iREMOVE,
	// Read request
	input logic iRD_REQ,
	input logic [31:0] iRD_ADDR,
	output logic oRD_BUSY,
	// Read result
	output logic oRD_VALID,
	output logic oRD_HIT,
	output cache_pkg::word_t oRD_DATA,
	input logic iRD_BUSY,
	// Line fill
	input logic iWR_REQ,
	input logic [31:0] iWR_ADDR,
	input cache_pkg::line_t iWR_DATA
);

	cache_pkg::addr_u rd_addr;
	cache_pkg::addr_u wr_addr;
	cache_pkg::line_t [cache_pkg::WAYS-1:0] way_lines;

	lookup_if lookup ();

	assign rd_addr.raw = iRD_ADDR;
	assign wr_addr.raw = iWR_ADDR;
	assign lookup.rd_index = rd_addr.fields.index;

	tag_store u_tag_store (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.remove(iREMOVE),
		.rd_addr(rd_addr),
		.wr_req(iWR_REQ),
		.wr_addr(wr_addr),
		.lookup(lookup.tag)
	);

	way_data_ram u_way_data_ram (
		.iCLOCK(iCLOCK),
		.wr_data(iWR_DATA),
		.lookup(lookup.ram),
		.way_lines(way_lines)
	);

	read_port u_read_port (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.remove(iREMOVE),
		.rd_req(iRD_REQ),
		.rd_addr(rd_addr),
		.rd_busy_in(iRD_BUSY),
		.wr_req(iWR_REQ),
		.wr_addr(wr_addr),
		.way_lines(way_lines),
		.rd_busy(oRD_BUSY),
		.rd_valid(oRD_VALID),
		.rd_hit(oRD_HIT),
		.rd_data(oRD_DATA),
		.lookup(lookup.port)
	);

endmodule

/* logic/lookup_if.sv */
// Lookup, fill and hold signals shared by the tag store, line RAM and read port
// One instance lives in the cache top, each block takes its own modport
`timescale 1ns/1ps

interface lookup_if;

	cache_pkg::index_t rd_index;	// Set of the current read address
	logic rd_accept;
	logic rd_hold;					// Consumer stall
	logic hit;
	cache_pkg::way_t hit_way;
	logic wr_en;
	cache_pkg::way_t wr_way;
	cache_pkg::index_t wr_index;

	// Timer and aging also stall under rd_hold
	modport tag (
		input rd_index, rd_accept, rd_hold,
		output hit, hit_way, wr_en, wr_way, wr_index
	);

	modport ram (
		input rd_index, rd_hold, wr_en, wr_way, wr_index
	);

	modport port (
		input hit, hit_way,
		output rd_accept, rd_hold
	);

endinterface

/* logic/read_port.sv */
// Requester side of the cache: read acceptance, busy, result registers
// and selection of the 64-bit word out of the hit line
`timescale 1ns/1ps

module read_port (
	input logic iCLOCK,
	input logic inRESET,
	input logic remove,
	input logic rd_req,
	input cache_pkg::addr_u rd_addr,
	input logic rd_busy_in,
	input logic wr_req,
	input cache_pkg::addr_u wr_addr,
	input cache_pkg::line_t [cache_pkg::WAYS-1:0] way_lines,
	output logic rd_busy,
	output logic rd_valid,
	output logic rd_hit,
	output cache_pkg::word_t rd_data,
	lookup_if.port lookup
);

	logic same_line;
	logic valid_q;
	logic hit_q;
	cache_pkg::way_t way_q;
	logic [cache_pkg::OFFSET_WIDTH-4:0] word_sel_q;
	cache_pkg::line_t sel_line;

	// Read and fill of one line in the same cycle
	assign same_line = wr_req &&
		rd_addr.fields.tag == wr_addr.fields.tag &&
		rd_addr.fields.index == wr_addr.fields.index;

	assign rd_busy = rd_busy_in || (rd_req && same_line);
	assign lookup.rd_accept = rd_req && !rd_busy;
	assign lookup.rd_hold = rd_busy_in;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= 1'b0;
			hit_q <= 1'b0;
		end else if (remove) begin
			valid_q <= 1'b0;
		end else if (!rd_busy_in) begin
			valid_q <= lookup.rd_accept;
			hit_q <= lookup.hit;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (!rd_busy_in) begin
			way_q <= lookup.hit_way;
			word_sel_q <= rd_addr.fields.offset[cache_pkg::OFFSET_WIDTH-1:3];
		end
	end

	assign rd_valid = valid_q && !rd_busy_in;	// Result hidden while held
	assign rd_hit = valid_q && hit_q && !rd_busy_in;

	assign sel_line = way_lines[way_q];
	assign rd_data = rd_hit ?
		sel_line[word_sel_q * cache_pkg::WORD_WIDTH +: cache_pkg::WORD_WIDTH] : '0;

endmodule

/* logic/tag_store.sv */
// Tag and age status array of the cache with hit lookup and fill way choice
// Also runs the free-running aging timer that lets old entries become victims
`timescale 1ns/1ps

module tag_store (
	input logic iCLOCK,
	input logic inRESET,
	input logic remove,
	input cache_pkg::addr_u rd_addr,
	input logic wr_req,
	input cache_pkg::addr_u wr_addr,
	lookup_if.tag lookup
);

	logic [cache_pkg::TAG_WIDTH-1:0] tag_q [cache_pkg::WAYS][cache_pkg::SETS];
	cache_pkg::status_t status_q [cache_pkg::WAYS][cache_pkg::SETS];
	logic [cache_pkg::AGE_TIMER_WIDTH-1:0] age_timer_q;
	logic age_tick;
	logic read_hit;
	cache_pkg::way_t read_way;
	cache_pkg::way_t victim_way;
	cache_pkg::index_t wr_set;

	assign wr_set = wr_addr.fields.index;

	// Aging timer, counts only unheld cycles
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			age_timer_q <= '0;
		end else if (remove) begin
			age_timer_q <= '0;
		end else if (!lookup.rd_hold) begin
			age_timer_q <= age_timer_q + 1'b1;
		end
	end

	assign age_tick = (&age_timer_q) && !lookup.rd_hold;

	// Read lookup, lowest matching way wins
	always_comb begin
		read_hit = 1'b0;
		read_way = '0;
		for (int w = cache_pkg::WAYS - 1; w >= 0; w--) begin
			if (tag_q[w][lookup.rd_index] == rd_addr.fields.tag &&
					status_q[w][lookup.rd_index] != cache_pkg::STATUS_INVALID) begin
				read_hit = 1'b1;
				read_way = cache_pkg::way_t'(w);
			end
		end
	end

	// Fill way: tag match first, then lowest status, way 3 if all are newest
	always_comb begin
		victim_way = cache_pkg::way_t'(cache_pkg::WAYS - 1);
		for (int lvl = 2; lvl >= 0; lvl--) begin
			for (int w = cache_pkg::WAYS - 1; w >= 0; w--) begin
				if (status_q[w][wr_set] == cache_pkg::status_t'(lvl)) begin
					victim_way = cache_pkg::way_t'(w);
				end
			end
		end
		for (int w = cache_pkg::WAYS - 1; w >= 0; w--) begin
			if (tag_q[w][wr_set] == wr_addr.fields.tag) begin
				victim_way = cache_pkg::way_t'(w);	// Reuse the line's own way
			end
		end
	end

	assign lookup.hit = read_hit;
	assign lookup.hit_way = read_way;
	assign lookup.wr_en = wr_req;
	assign lookup.wr_way = victim_way;
	assign lookup.wr_index = wr_set;

	always_ff @(posedge iCLOCK) begin
		if (wr_req) begin
			tag_q[victim_way][wr_set] <= wr_addr.fields.tag;
		end
	end

	// Status update, a fill takes priority over refresh and aging
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int w = 0; w < cache_pkg::WAYS; w++) begin
				for (int s = 0; s < cache_pkg::SETS; s++) begin
					status_q[w][s] <= cache_pkg::STATUS_INVALID;
				end
			end
		end else if (remove) begin
			for (int w = 0; w < cache_pkg::WAYS; w++) begin
				for (int s = 0; s < cache_pkg::SETS; s++) begin
					status_q[w][s] <= cache_pkg::STATUS_INVALID;
				end
			end
		end else if (wr_req) begin
			status_q[victim_way][wr_set] <= cache_pkg::STATUS_NEWEST;
		end else begin
			if (age_tick) begin
				for (int w = 0; w < cache_pkg::WAYS; w++) begin
					for (int s = 0; s < cache_pkg::SETS; s++) begin
						if (status_q[w][s] >= 2'd2) begin
							status_q[w][s] <= status_q[w][s] - 2'd1;
						end
					end
				end
			end
			// Later assignment overrides aging of the refreshed entry
			if (lookup.rd_accept && read_hit) begin
				status_q[read_way][lookup.rd_index] <= cache_pkg::STATUS_NEWEST;
			end
		end
	end

endmodule

/* logic/way_data_ram.sv */
// Line storage for all four ways, 16 lines of 512 bits each
// One write port for fills, one registered read port that reads every way at once
`timescale 1ns/1ps

module way_data_ram (
	input logic iCLOCK,
	input cache_pkg::line_t wr_data,
	lookup_if.ram lookup,
	output cache_pkg::line_t [cache_pkg::WAYS-1:0] way_lines
);

	cache_pkg::line_t mem [cache_pkg::WAYS][cache_pkg::SETS];

	// Fill writes only the chosen way
	always_ff @(posedge iCLOCK) begin
		if (lookup.wr_en) begin
			mem[lookup.wr_way][lookup.wr_index] <= wr_data;
		end
	end

	// Read side
	// All ways are read so the hit way can be picked after the register,
	// in step with the way number held in the read port
	always_ff @(posedge iCLOCK) begin
		if (!lookup.rd_hold) begin
			for (int w = 0; w < cache_pkg::WAYS; w++) begin
				way_lines[w] <= mem[w][lookup.rd_index];
			end
		end
	end

endmodule

/* tests/l1_read_cache_sva.sv */
// Output rules of the read cache, bound into the cache top
`timescale 1ns/1ps

module l1_read_cache_sva (
	input logic iCLOCK,
	input logic inRESET,
	input logic iREMOVE,
	input logic oRD_VALID,
	input logic oRD_HIT,
	input cache_pkg::word_t oRD_DATA
);

	hit_needs_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		oRD_HIT |-> oRD_VALID)
		else $error("oRD_HIT high without oRD_VALID");

	// First cycle out of reset has no result
	no_valid_after_reset: assert property (@(posedge iCLOCK)
		$rose(inRESET) |-> !oRD_VALID)
		else $error("oRD_VALID high right after reset");

	no_valid_after_remove: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		iREMOVE |=> !oRD_VALID)
		else $error("oRD_VALID high in the cycle after remove");

	data_zero_on_miss: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!oRD_HIT |-> oRD_DATA == '0)
		else $error("oRD_DATA nonzero without a hit");

endmodule

bind l1_read_cache l1_read_cache_sva sva0 (
	.iCLOCK(iCLOCK),
	.inRESET(inRESET),
	.iREMOVE(iREMOVE),
	.oRD_VALID(oRD_VALID),
	.oRD_HIT(oRD_HIT),
	.oRD_DATA(oRD_DATA)
);

/* tests/l1_read_cache_tb.sv */
// Testbench for the L1 read cache that applies a table of fills, reads, holds and removes
// in order and checks each result against a reference model of tags, ages and lines
`timescale 1ns/1ps

module l1_read_cache_tb;

	localparam int CLK_PERIOD = 8;
	localparam int SAMPLE_DELAY = 2;	// Outputs settle after the falling edge drive
	localparam int RESET_CYCLES = 3;
	localparam int AGE_PERIOD = 1 << cache_pkg::AGE_TIMER_WIDTH;
	localparam int OP_CYCLES = 8;	// Upper bound per table step
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;

	typedef enum logic [2:0] {
		OP_FILL, OP_READ, OP_REMOVE, OP_HOLD_READ, OP_COLLIDE, OP_AGE_WAIT
	} op_e;

	typedef struct packed {
		op_e op;
		logic [31:0] addr;
		logic hit;
	} step_t;

	logic iCLOCK;
	logic inRESET;
	logic iREMOVE;
	logic iRD_REQ;
	logic [31:0] iRD_ADDR;
	logic oRD_BUSY;
	logic oRD_VALID;
	logic oRD_HIT;
	cache_pkg::word_t oRD_DATA;
	logic iRD_BUSY;
	logic iWR_REQ;
	logic [31:0] iWR_ADDR;
	cache_pkg::line_t iWR_DATA;

	step_t steps [$];
	logic [31:0] lfsr_state;
	int error_count;
	int check_count;

	// Reference model state
	logic [21:0] m_tag [cache_pkg::WAYS][cache_pkg::SETS];
	logic m_known [cache_pkg::WAYS][cache_pkg::SETS];
	int m_status [cache_pkg::WAYS][cache_pkg::SETS];
	cache_pkg::line_t m_line [cache_pkg::WAYS][cache_pkg::SETS];
	int m_timer;	// Unheld cycles since reset or remove
	logic exp_hit;
	cache_pkg::word_t exp_word;

	l1_read_cache dut0 (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.iREMOVE(iREMOVE),
		.iRD_REQ(iRD_REQ),
		.iRD_ADDR(iRD_ADDR),
		.oRD_BUSY(oRD_BUSY),
		.oRD_VALID(oRD_VALID),
		.oRD_HIT(oRD_HIT),
		.oRD_DATA(oRD_DATA),
		.iRD_BUSY(iRD_BUSY),
		.iWR_REQ(iWR_REQ),
		.iWR_ADDR(iWR_ADDR),
		.iWR_DATA(iWR_DATA)
	);

	always #(CLK_PERIOD / 2) iCLOCK = ~iCLOCK;

	function automatic logic [31:0] make_addr(input logic [21:0] tag, input logic [3:0] set,
			input logic [5:0] offset);
		return {tag, set, offset};
	endfunction

	function automatic int set_of(input logic [31:0] addr);
		return int'(addr[9:6]);
	endfunction

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ LFSR_TAPS;
		return state >> 1;
	endfunction

	// One LFSR step per data bit
	task automatic make_fill_line(output cache_pkg::line_t line);
		for (int b = 0; b < cache_pkg::LINE_WIDTH; b++) begin
			line[b] = lfsr_state[0];
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	// Lowest valid way holding the tag or -1 on a miss
	function automatic int find_hit_way(input logic [31:0] addr);
		for (int w = 0; w < cache_pkg::WAYS; w++)
			if (m_known[w][set_of(addr)] && m_tag[w][set_of(addr)] == addr[31:10] &&
					m_status[w][set_of(addr)] != 0)
				return w;
		return -1;
	endfunction

	function automatic int find_fill_way(input logic [31:0] addr);
		for (int w = 0; w < cache_pkg::WAYS; w++)
			if (m_known[w][set_of(addr)] && m_tag[w][set_of(addr)] == addr[31:10])
				return w;
		for (int age = 0; age < 3; age++)
			for (int w = 0; w < cache_pkg::WAYS; w++)
				if (m_status[w][set_of(addr)] == age)
					return w;
		return cache_pkg::WAYS - 1;
	endfunction

	// Applies one clock edge to the model using the inputs driven before it
	task automatic model_edge();
		logic busy;
		logic tick;
		int hit_way;
		int way;
		hit_way = -1;
		if (iREMOVE) begin
			foreach (m_status[w, s])
				m_status[w][s] = 0;
			m_timer = 0;
		end else begin
			busy = iRD_BUSY || (iRD_REQ && iWR_REQ && iRD_ADDR[31:6] == iWR_ADDR[31:6]);
			tick = m_timer == AGE_PERIOD - 1 && !iRD_BUSY;
			if (iRD_REQ && !busy) begin
				hit_way = find_hit_way(iRD_ADDR);
				exp_hit = hit_way >= 0;
				exp_word = '0;
				if (hit_way >= 0)
					exp_word = m_line[hit_way][set_of(iRD_ADDR)][int'(iRD_ADDR[5:3]) * 64 +: 64];
			end
			if (iWR_REQ) begin	// Fill wins over refresh and aging
				way = find_fill_way(iWR_ADDR);
				m_tag[way][set_of(iWR_ADDR)] = iWR_ADDR[31:10];
				m_known[way][set_of(iWR_ADDR)] = 1'b1;
				m_status[way][set_of(iWR_ADDR)] = 3;
				m_line[way][set_of(iWR_ADDR)] = iWR_DATA;
			end else begin
				if (tick)
					foreach (m_status[w, s])
						if (m_status[w][s] >= 2)
							m_status[w][s] = m_status[w][s] - 1;
				if (hit_way >= 0)
					m_status[hit_way][set_of(iRD_ADDR)] = 3;
			end
			if (!iRD_BUSY)
				m_timer = (m_timer + 1) % AGE_PERIOD;
		end
	endtask

	always @(posedge iCLOCK) begin
		if (inRESET)
			model_edge();
	end

	task automatic check_flag(input string name, input logic actual, input logic expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
		end
	endtask

	task automatic check_word(input string name, input cache_pkg::word_t actual,
			input cache_pkg::word_t expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic check_result(input step_t s);
		check_flag("oRD_VALID", oRD_VALID, 1'b1);
		check_flag("oRD_HIT", oRD_HIT, s.hit);
		if (exp_hit !== s.hit) begin
			error_count++;
			$display("At %0t the reference model and the table disagree on a hit at %h",
				$time, s.addr);
		end
		check_word("oRD_DATA", oRD_DATA, s.hit ? exp_word : '0);
	endtask

	task automatic add_step(input op_e op, input logic [31:0] addr, input logic hit);
		step_t s;
		s.op = op;
		s.addr = addr;
		s.hit = hit;
		steps.push_back(s);
	endtask

	task automatic build_table();
		add_step(OP_FILL, make_addr(22'h012345, 4'd1, 6'd0), 1'b0);
		for (int i = 0; i < 8; i++)
			add_step(OP_READ, make_addr(22'h012345, 4'd1, 6'(i * 8)), 1'b1);
		add_step(OP_READ, make_addr(22'h000777, 4'd1, 6'd16), 1'b0);
		add_step(OP_READ, make_addr(22'h012345, 4'd5, 6'd0), 1'b0);
		// Five lines into set 2 so the fifth takes way 3
		for (int i = 0; i < 5; i++)
			add_step(OP_FILL, make_addr(22'(22'h000100 + i), 4'd2, 6'd0), 1'b0);
		add_step(OP_READ, make_addr(22'h000103, 4'd2, 6'd8), 1'b0);
		add_step(OP_READ, make_addr(22'h000100, 4'd2, 6'd0), 1'b1);
		add_step(OP_READ, make_addr(22'h000101, 4'd2, 6'd48), 1'b1);
		add_step(OP_READ, make_addr(22'h000102, 4'd2, 6'd56), 1'b1);
		add_step(OP_READ, make_addr(22'h000104, 4'd2, 6'd32), 1'b1);
		add_step(OP_HOLD_READ, make_addr(22'h000100, 4'd2, 6'd40), 1'b1);
		add_step(OP_HOLD_READ, make_addr(22'h000103, 4'd2, 6'd0), 1'b0);
		add_step(OP_COLLIDE, make_addr(22'h012345, 4'd1, 6'd24), 1'b0);
		add_step(OP_READ, make_addr(22'h012345, 4'd1, 6'd24), 1'b1);
		add_step(OP_REMOVE, make_addr(22'h012345, 4'd1, 6'd0), 1'b0);
		add_step(OP_READ, make_addr(22'h012345, 4'd1, 6'd0), 1'b0);
		add_step(OP_READ, make_addr(22'h000100, 4'd2, 6'd0), 1'b0);
		add_step(OP_READ, make_addr(22'h000104, 4'd2, 6'd0), 1'b0);
		// Set 3 ages until way 0 becomes the victim
		for (int i = 0; i < 4; i++)
			add_step(OP_FILL, make_addr(22'(22'h002000 + i), 4'd3, 6'd0), 1'b0);
		add_step(OP_AGE_WAIT, 32'h0, 1'b0);
		add_step(OP_READ, make_addr(22'h002001, 4'd3, 6'd8), 1'b1);
		add_step(OP_FILL, make_addr(22'h002004, 4'd3, 6'd0), 1'b0);
		add_step(OP_READ, make_addr(22'h002000, 4'd3, 6'd0), 1'b0);
		add_step(OP_READ, make_addr(22'h002001, 4'd3, 6'd16), 1'b1);
		add_step(OP_READ, make_addr(22'h002004, 4'd3, 6'd56), 1'b1);
		add_step(OP_READ, make_addr(22'h002003, 4'd3, 6'd0), 1'b1);
	endtask

	task automatic run_step(input step_t s);
		cache_pkg::line_t line;
		@(negedge iCLOCK);
		case (s.op)
			OP_FILL: begin
				make_fill_line(line);
				iWR_REQ = 1'b1;
				iWR_ADDR = s.addr;
				iWR_DATA = line;
				@(negedge iCLOCK);
				iWR_REQ = 1'b0;
			end
			OP_READ: begin
				iRD_REQ = 1'b1;
				iRD_ADDR = s.addr;
				#SAMPLE_DELAY;
				check_flag("oRD_BUSY", oRD_BUSY, 1'b0);
				@(negedge iCLOCK);
				iRD_REQ = 1'b0;
				#SAMPLE_DELAY;
				check_result(s);
			end
			OP_HOLD_READ: begin
				iRD_REQ = 1'b1;
				iRD_ADDR = s.addr;
				@(negedge iCLOCK);
				iRD_REQ = 1'b0;
				iRD_ADDR = ~s.addr;	// Another set and word while held
				iRD_BUSY = 1'b1;
				repeat (3) begin
					#SAMPLE_DELAY;
					check_flag("oRD_VALID", oRD_VALID, 1'b0);
					check_flag("oRD_HIT", oRD_HIT, 1'b0);
					check_flag("oRD_BUSY", oRD_BUSY, 1'b1);
					@(negedge iCLOCK);
				end
				iRD_BUSY = 1'b0;	// Held result shows until the next edge
				#SAMPLE_DELAY;
				check_result(s);
			end
			OP_COLLIDE: begin
				make_fill_line(line);
				iRD_REQ = 1'b1;
				iRD_ADDR = s.addr;
				iWR_REQ = 1'b1;
				iWR_ADDR = s.addr;
				iWR_DATA = line;
				#SAMPLE_DELAY;
				check_flag("oRD_BUSY", oRD_BUSY, 1'b1);
				@(negedge iCLOCK);
				iRD_REQ = 1'b0;
				iWR_REQ = 1'b0;
				#SAMPLE_DELAY;
				check_flag("oRD_VALID", oRD_VALID, 1'b0);
			end
			OP_REMOVE: begin
				iREMOVE = 1'b1;
				iRD_REQ = 1'b1;	// Remove beats a read in the same cycle
				iRD_ADDR = s.addr;
				@(negedge iCLOCK);
				iREMOVE = 1'b0;
				iRD_REQ = 1'b0;
				#SAMPLE_DELAY;
				check_flag("oRD_VALID", oRD_VALID, 1'b0);
				check_flag("oRD_HIT", oRD_HIT, 1'b0);
			end
			OP_AGE_WAIT: repeat (2 * AGE_PERIOD) @(negedge iCLOCK);
			default: ;
		endcase
	endtask

	task automatic run_watchdog(input int limit_cycles);
		#(limit_cycles * CLK_PERIOD);
		$display("Timeout after %0d cycles, the table did not complete (errors so far: %0d)",
			limit_cycles, error_count);
		$display("sim failed");
		$finish;
	endtask

	initial begin
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		iREMOVE = 1'b0;
		iRD_REQ = 1'b0;
		iRD_ADDR = '0;
		iRD_BUSY = 1'b0;
		iWR_REQ = 1'b0;
		iWR_ADDR = '0;
		iWR_DATA = '0;
		lfsr_state = 32'd23;
		error_count = 0;
		check_count = 0;
		foreach (m_status[w, s]) begin
			m_status[w][s] = 0;
			m_known[w][s] = 1'b0;
		end
		m_timer = 0;
		build_table();
		fork
			run_watchdog(steps.size() * OP_CYCLES + 3 * AGE_PERIOD + RESET_CYCLES + 4);
		join_none
		repeat (RESET_CYCLES) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1;
		foreach (steps[i])
			run_step(steps[i]);
		@(negedge iCLOCK);
		$display("Steps: %0d, checks: %0d, errors: %0d", steps.size(), check_count, error_count);
		if (error_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule
